/* hdl/sif_cpl_pkg.sv */
package sif_cpl_pkg;

  localparam int SIF_TAG_W  = 3;
  localparam int SIF_TAGS   = 1 << SIF_TAG_W;
  localparam int SIF_DATA_W = 32;

  // successful completion status.
  localparam logic [1:0] SIF_CPL_SC = 2'b00;

  // header kind, top two bits of every header.
  typedef enum logic [1:0] {
    SIF_KIND_REQ  = 2'b00,
    SIF_KIND_CPL  = 2'b01,
    SIF_KIND_RSV2 = 2'b10,
    SIF_KIND_RSV3 = 2'b11
  } sif_kind_e;

  // header seen as a read request.
  typedef struct packed {
    sif_kind_e            kind;
    logic [SIF_TAG_W-1:0] tag;
    logic [2:0]           length;
    logic [23:0]          addr;
  } sif_req_hdr_t;

  // header seen as a completion.
  typedef struct packed {
    sif_kind_e            kind;
    logic [SIF_TAG_W-1:0] tag;
    logic [1:0]           status;
    logic [8:0]           rsvd;
    logic [15:0]          byte_cnt;
  } sif_cpl_hdr_t;

  // kind field picks the valid view.
  typedef union packed {
    sif_req_hdr_t req;
    sif_cpl_hdr_t cpl;
  } sif_hdr_u;

  // classified word, decode to execute.
  typedef struct packed {
    logic                  req_vld;
    logic                  cpl_vld;
    logic [SIF_TAG_W-1:0]  tag;
    logic                  sts_good;
    logic [SIF_DATA_W-1:0] data;
  } sif_dec_t;

endpackage

/* hdl/sif_alarm_pkg.sv */
package sif_alarm_pkg;

  localparam int SIF_FIFO_DEPTH = 8;
  localparam int SIF_FIFO_AW    = $clog2(SIF_FIFO_DEPTH);
  localparam int SIF_TIMEOUT    = 64;
  localparam int SIF_AGE_W      = $clog2(SIF_TIMEOUT);

  // last age value before a tag expires.
  localparam logic [SIF_AGE_W-1:0]   SIF_AGE_MAX = SIF_AGE_W'(SIF_TIMEOUT - 1);
  localparam logic [SIF_FIFO_AW:0]   SIF_FIFO_FULL = (SIF_FIFO_AW + 1)'(SIF_FIFO_DEPTH);
  localparam logic [SIF_FIFO_AW-1:0] SIF_PTR_ONE = SIF_FIFO_AW'(1);

  // sticky alarm bits, also used for per-cycle error strobes.
  typedef struct packed {
    logic hdr_perr;
    logic data_perr;
    logic malformed;
    logic unexp_cpl;
    logic timeout;
    logic fifo_ovf;
    logic fifo_unf;
  } sif_alarm_t;

  typedef struct packed {
    logic [sif_cpl_pkg::SIF_TAG_W-1:0]  tag;
    logic [sif_cpl_pkg::SIF_DATA_W-1:0] data;
  } sif_fifo_ent_t;

endpackage

/* hdl/sif_cpl_decode.sv */
module sif_cpl_decode (
  input  logic                               hqm_sif_core,
  input  logic                               i_rst_n,
  input  logic                               i_valid,
  input  sif_cpl_pkg::sif_hdr_u              i_hdr,
  input  logic                               i_hdr_par,
  input  logic [sif_cpl_pkg::SIF_DATA_W-1:0] i_data,
  input  logic                               i_data_par,
  output sif_cpl_pkg::sif_dec_t              o_dec,
  output sif_alarm_pkg::sif_alarm_t          o_err
);

  logic hdr_bad;
  logic data_bad;
  logic is_req;
  logic is_cpl;
  logic req_ok;
  logic cpl_ok;
  sif_alarm_pkg::sif_alarm_t err;

  always_comb begin
    is_req = 1'b0;
    is_cpl = 1'b0;
    case (i_hdr.req.kind)
      sif_cpl_pkg::SIF_KIND_REQ: is_req = 1'b1;
      sif_cpl_pkg::SIF_KIND_CPL: is_cpl = 1'b1;
      default: ;
    endcase
    // even parity.
    hdr_bad  = i_hdr_par != ^i_hdr;
    data_bad = i_data_par != ^i_data;

    req_ok = i_valid && !hdr_bad && is_req;
    cpl_ok = i_valid && !hdr_bad && is_cpl && !data_bad;

    err           = '0;
    err.hdr_perr  = i_valid && hdr_bad;
    // data parity only matters on completions.
    err.data_perr = i_valid && !hdr_bad && is_cpl && data_bad;
    err.malformed = i_valid && !hdr_bad && !is_req && !is_cpl;
  end

  always_ff @(posedge hqm_sif_core) begin
    if (!i_rst_n) begin
      o_dec.req_vld <= 1'b0;
      o_dec.cpl_vld <= 1'b0;
      o_err         <= '0;
    end else begin
      o_dec.req_vld <= req_ok;
      o_dec.cpl_vld <= cpl_ok;
      o_err         <= err;
      if (i_valid) begin
        // tag sits at the same bits in both views.
        o_dec.tag      <= i_hdr.req.tag;
        o_dec.sts_good <= i_hdr.cpl.status == sif_cpl_pkg::SIF_CPL_SC;
        o_dec.data     <= i_data;
      end
    end
  end

endmodule

/* hdl/sif_cpl_scrbd.sv */
module sif_cpl_scrbd (
  input  logic                         hqm_sif_core,
  input  logic                         i_rst_n,
  input  sif_cpl_pkg::sif_dec_t        i_dec,
  output logic                         o_push,
  output sif_alarm_pkg::sif_fifo_ent_t o_push_ent,
  output sif_alarm_pkg::sif_alarm_t    o_err
);

  logic [sif_cpl_pkg::SIF_TAGS-1:0]  outst;
  logic [sif_alarm_pkg::SIF_AGE_W-1:0] age [sif_cpl_pkg::SIF_TAGS];
  logic [sif_cpl_pkg::SIF_TAGS-1:0]  hit;
  logic [sif_cpl_pkg::SIF_TAGS-1:0]  expire;
  logic                              cpl_hit;
  logic                              cpl_unexp;

  always_comb begin
    hit = '0;
    if (i_dec.req_vld || i_dec.cpl_vld) begin
      hit[i_dec.tag] = 1'b1;
    end
    // a word to the same tag wins over expiry.
    for (int t = 0; t < sif_cpl_pkg::SIF_TAGS; t++) begin
      expire[t] = outst[t] && !hit[t] && (age[t] == sif_alarm_pkg::SIF_AGE_MAX);
    end
    cpl_hit   = i_dec.cpl_vld && outst[i_dec.tag];
    cpl_unexp = i_dec.cpl_vld && !outst[i_dec.tag];
  end

  always_ff @(posedge hqm_sif_core) begin
    if (!i_rst_n) begin
      outst  <= '0;
      o_push <= 1'b0;
      o_err  <= '0;
    end else begin
      outst <= outst & ~expire;
      if (i_dec.req_vld) begin
        outst[i_dec.tag] <= 1'b1;
      end
      if (cpl_hit) begin
        outst[i_dec.tag] <= 1'b0;
      end
      // bad status retires the tag silently.
      o_push          <= cpl_hit && i_dec.sts_good;
      o_err           <= '0;
      o_err.unexp_cpl <= cpl_unexp;
      o_err.timeout   <= |expire;
      if (cpl_hit) begin
        o_push_ent.tag  <= i_dec.tag;
        o_push_ent.data <= i_dec.data;
      end
    end
  end

  // age counters, only meaningful while outstanding.
  always_ff @(posedge hqm_sif_core) begin
    for (int t = 0; t < sif_cpl_pkg::SIF_TAGS; t++) begin
      if (hit[t] && i_dec.req_vld) begin
        age[t] <= '0;
      end else if (outst[t]) begin
        age[t] <= age[t] + 1'b1;
      end
    end
  end

endmodule

/* hdl/sif_cpl_result.sv */
module sif_cpl_result (
  input  logic                         hqm_sif_core,
  input  logic                         i_rst_n,
  input  logic                         i_push,
  input  sif_alarm_pkg::sif_fifo_ent_t i_push_ent,
  input  logic                         i_pop,
  input  logic                         i_alarm_clr,
  input  sif_alarm_pkg::sif_alarm_t    i_dec_err,
  input  sif_alarm_pkg::sif_alarm_t    i_scrbd_err,
  output sif_alarm_pkg::sif_fifo_ent_t o_rd_data,
  output logic                         o_rd_valid,
  output logic                         o_empty,
  output sif_alarm_pkg::sif_alarm_t    o_alarm
);

  sif_alarm_pkg::sif_fifo_ent_t mem [sif_alarm_pkg::SIF_FIFO_DEPTH];

  logic [sif_alarm_pkg::SIF_FIFO_AW-1:0] wr_ptr;
  logic [sif_alarm_pkg::SIF_FIFO_AW-1:0] rd_ptr;
  logic [sif_alarm_pkg::SIF_FIFO_AW:0]   count;
  logic                                  full;
  logic                                  empty;
  logic                                  push_ok;
  logic                                  pop_ok;
  sif_alarm_pkg::sif_alarm_t             fifo_err;

  always_comb begin
    full    = count == sif_alarm_pkg::SIF_FIFO_FULL;
    empty   = count == '0;
    // a push at full is dropped even with a pop.
    push_ok = i_push && !full;
    pop_ok  = i_pop && !empty;

    fifo_err          = '0;
    fifo_err.fifo_ovf = i_push && full;
    fifo_err.fifo_unf = i_pop && empty;
  end

  assign o_empty = empty;

  always_ff @(posedge hqm_sif_core) begin
    if (!i_rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_rd_valid <= 1'b0;
    end else begin
      // depth is a power of two, pointers wrap.
      if (push_ok) begin
        wr_ptr <= wr_ptr + sif_alarm_pkg::SIF_PTR_ONE;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + sif_alarm_pkg::SIF_PTR_ONE;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + {{sif_alarm_pkg::SIF_FIFO_AW{1'b0}}, 1'b1};
        2'b01:   count <= count - {{sif_alarm_pkg::SIF_FIFO_AW{1'b0}}, 1'b1};
        default: count <= count;
      endcase
      o_rd_valid <= pop_ok;
    end
  end

  always_ff @(posedge hqm_sif_core) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_push_ent;
    end
    if (pop_ok) begin
      o_rd_data <= mem[rd_ptr];
    end
  end

  // sticky, a new error beats the clear.
  always_ff @(posedge hqm_sif_core) begin
    if (!i_rst_n) begin
      o_alarm <= '0;
    end else begin
      o_alarm <= (i_alarm_clr ? '0 : o_alarm) | i_dec_err | i_scrbd_err | fifo_err;
    end
  end

endmodule

/* hdl/sif_cpl_core.sv */
module sif_cpl_core (
  input  logic                               hqm_sif_core,
  input  logic                               i_rst_n,
  input  logic                               i_valid,
  input  sif_cpl_pkg::sif_hdr_u              i_hdr,
  input  logic                               i_hdr_par,
  input  logic [sif_cpl_pkg::SIF_DATA_W-1:0] i_data,
  input  logic                               i_data_par,
  input  logic                               i_pop,
  input  logic                               i_alarm_clr,
  output sif_alarm_pkg::sif_fifo_ent_t       o_rd_data,
  output logic                               o_rd_valid,
  output logic                               o_empty,
  output sif_alarm_pkg::sif_alarm_t          o_alarm
);

  sif_cpl_pkg::sif_dec_t        dec;
  sif_alarm_pkg::sif_alarm_t    dec_err;
  logic                         push;
  sif_alarm_pkg::sif_fifo_ent_t push_ent;
  sif_alarm_pkg::sif_alarm_t    scrbd_err;

  sif_cpl_decode u_decode (
    .hqm_sif_core (hqm_sif_core),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_hdr        (i_hdr),
    .i_hdr_par    (i_hdr_par),
    .i_data       (i_data),
    .i_data_par   (i_data_par),
    .o_dec        (dec),
    .o_err        (dec_err)
  );

  sif_cpl_scrbd u_scrbd (
    .hqm_sif_core (hqm_sif_core),
    .i_rst_n      (i_rst_n),
    .i_dec        (dec),
    .o_push       (push),
    .o_push_ent   (push_ent),
    .o_err        (scrbd_err)
  );

  sif_cpl_result u_result (
    .hqm_sif_core (hqm_sif_core),
    .i_rst_n      (i_rst_n),
    .i_push       (push),
    .i_push_ent   (push_ent),
    .i_pop        (i_pop),
    .i_alarm_clr  (i_alarm_clr),
    .i_dec_err    (dec_err),
    .i_scrbd_err  (scrbd_err),
    .o_rd_data    (o_rd_data),
    .o_rd_valid   (o_rd_valid),
    .o_empty      (o_empty),
    .o_alarm      (o_alarm)
  );

endmodule

/* verification/sif_cpl_assert.sv */
module sif_cpl_assert (
  input logic                                 hqm_sif_core,
  input logic                                 i_rst_n,
  input logic [sif_alarm_pkg::SIF_FIFO_AW:0]  i_count,
  input logic                                 i_push,
  input logic                                 i_pop,
  input logic                                 i_empty,
  input sif_alarm_pkg::sif_alarm_t            i_alarm
);
  timeunit 1ns;
  timeprecision 1ps;

  count_in_range: assert property (@(posedge hqm_sif_core) disable iff (!i_rst_n)
    i_count <= sif_alarm_pkg::SIF_FIFO_FULL)
    else $error("fifo count above depth");

  ovf_flagged: assert property (@(posedge hqm_sif_core) disable iff (!i_rst_n)
    i_push && i_count == sif_alarm_pkg::SIF_FIFO_FULL |=> i_alarm.fifo_ovf)
    else $error("push at full without fifo_ovf");

  unf_flagged: assert property (@(posedge hqm_sif_core) disable iff (!i_rst_n)
    i_pop && i_empty |=> i_alarm.fifo_unf)
    else $error("pop at empty without fifo_unf");

endmodule

bind sif_cpl_core sif_cpl_assert u_assert (
  .hqm_sif_core (hqm_sif_core),
  .i_rst_n      (i_rst_n),
  .i_count      (u_result.count),
  .i_push       (push),
  .i_pop        (i_pop),
  .i_empty      (o_empty),
  .i_alarm      (o_alarm)
);

/* verification/sif_cpl_tb.sv */
module sif_cpl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [2:0] K_REQ  = 3'd0;
  localparam logic [2:0] K_CPL  = 3'd1;
  localparam logic [2:0] K_RSV2 = 3'd2;
  localparam logic [2:0] K_RSV3 = 3'd3;
  localparam logic [2:0] K_NONE = 3'd4;
  // alarm order hdr_perr, data_perr, malformed, unexp_cpl, timeout, ovf, unf.
  localparam logic [6:0] A_NONE = 7'b0000000;
  localparam logic [6:0] A_HP   = 7'b1000000;
  localparam logic [6:0] A_DP   = 7'b0100000;
  localparam logic [6:0] A_MF   = 7'b0010000;
  localparam logic [6:0] A_UX   = 7'b0001000;
  localparam logic [6:0] A_TO   = 7'b0000100;
  localparam logic [6:0] A_OV   = 7'b0000010;
  localparam logic [6:0] A_UF   = 7'b0000001;
  localparam int IDLE = 3;

  typedef struct packed {
    logic [2:0]                kind;
    logic [2:0]                tag;
    logic [1:0]                sts;
    logic                      fhp;
    logic                      fdp;
    int                        idle;
    int                        pops;
    sif_alarm_pkg::sif_alarm_t mask;
  } row_t;

  logic                         hqm_sif_core;
  logic                         i_rst_n;
  logic                         i_valid;
  sif_cpl_pkg::sif_hdr_u        i_hdr;
  logic                         i_hdr_par;
  logic [31:0]                  i_data;
  logic                         i_data_par;
  logic                         i_pop;
  logic                         i_alarm_clr;
  sif_alarm_pkg::sif_fifo_ent_t o_rd_data;
  logic                         o_rd_valid;
  logic                         o_empty;
  sif_alarm_pkg::sif_alarm_t    o_alarm;

  row_t                         tests [$];
  sif_alarm_pkg::sif_fifo_ent_t fifo_q [$];
  sif_alarm_pkg::sif_fifo_ent_t last_rd;
  logic [7:0]                   outst;
  int                           issued [8];
  logic [31:0]                  lfsr;
  int                           cyc = 0;
  int                           limit = 0;
  int                           errors = 0;
  int                           checks = 0;

  sif_cpl_core uut (.*);

  always #10 hqm_sif_core = ~hqm_sif_core;

  always @(posedge hqm_sif_core) begin
    cyc <= cyc + 1;
    if (limit > 0 && cyc >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic row_t row(input logic [2:0] kind, input logic [2:0] tag,
      input logic [1:0] sts, input logic fhp, input logic fdp, input int idle,
      input int pops, input logic [6:0] mask);
    row_t r;
    r.kind = kind;
    r.tag  = tag;
    r.sts  = sts;
    r.fhp  = fhp;
    r.fdp  = fdp;
    r.idle = idle;
    r.pops = pops;
    r.mask = mask;
    return r;
  endfunction

  // galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp == act) else begin
      $display("error: t=%0t %s expected %0h got %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic model_word(input row_t r, input logic [31:0] data);
    sif_alarm_pkg::sif_fifo_ent_t ent;
    // expiry lands two cycles after the age limit.
    for (int t = 0; t < 8; t++) begin
      if (outst[t] && cyc - issued[t] > sif_alarm_pkg::SIF_TIMEOUT + 2) begin
        outst[t] = 1'b0;
      end
    end
    if (r.fhp) begin
      return;
    end
    if (r.kind == K_REQ) begin
      outst[r.tag]  = 1'b1;
      issued[r.tag] = cyc;
    end else if (r.kind == K_CPL && !r.fdp && outst[r.tag]) begin
      outst[r.tag] = 1'b0;
      if (r.sts == 2'b00 && fifo_q.size() < sif_alarm_pkg::SIF_FIFO_DEPTH) begin
        ent.tag  = r.tag;
        ent.data = data;
        fifo_q.push_back(ent);
      end
    end
  endtask

  task automatic send_word(input row_t r);
    sif_cpl_pkg::sif_hdr_u hdr;
    logic [31:0]           data;
    logic [31:0]           bits;
    take_bits(32, data);
    hdr = '0;
    if (r.kind == K_REQ) begin
      take_bits(27, bits);
      hdr.req.kind   = sif_cpl_pkg::SIF_KIND_REQ;
      hdr.req.tag    = r.tag;
      hdr.req.length = bits[26:24];
      hdr.req.addr   = bits[23:0];
    end else begin
      take_bits(16, bits);
      hdr.cpl.kind     = sif_cpl_pkg::sif_kind_e'(r.kind[1:0]);
      hdr.cpl.tag      = r.tag;
      hdr.cpl.status   = r.sts;
      hdr.cpl.byte_cnt = bits[15:0];
    end
    @(posedge hqm_sif_core);
    i_valid    <= 1'b1;
    i_hdr      <= hdr;
    i_hdr_par  <= (^hdr) ^ r.fhp;
    i_data     <= data;
    i_data_par <= (^data) ^ r.fdp;
    model_word(r, data);
    @(posedge hqm_sif_core);
    i_valid <= 1'b0;
  endtask

  task automatic pop_one();
    sif_alarm_pkg::sif_fifo_ent_t exp;
    logic                         hit;
    hit = fifo_q.size() != 0;
    @(posedge hqm_sif_core);
    i_pop <= 1'b1;
    @(posedge hqm_sif_core);
    i_pop <= 1'b0;
    @(negedge hqm_sif_core);
    check_val("o_rd_valid", 64'(hit), 64'(o_rd_valid));
    if (hit) begin
      exp = fifo_q.pop_front();
      check_val("o_rd_data.tag", 64'(exp.tag), 64'(o_rd_data.tag));
      check_val("o_rd_data.data", 64'(exp.data), 64'(o_rd_data.data));
      last_rd = exp;
    end else begin
      // an empty pop keeps the last read entry.
      check_val("o_rd_data", 64'(last_rd), 64'(o_rd_data));
    end
  endtask

  task automatic run_test(input int idx, input row_t r);
    int err0;
    err0 = errors;
    @(posedge hqm_sif_core);
    i_alarm_clr <= 1'b1;
    @(posedge hqm_sif_core);
    i_alarm_clr <= 1'b0;
    @(negedge hqm_sif_core);
    check_val("o_alarm", 64'(A_NONE), 64'(o_alarm));
    if (r.kind != K_NONE) begin
      send_word(r);
    end
    repeat (r.idle) @(posedge hqm_sif_core);
    repeat (r.pops) pop_one();
    @(negedge hqm_sif_core);
    check_val("o_alarm", 64'(r.mask), 64'(o_alarm));
    check_val("o_empty", 64'(fifo_q.size() == 0), 64'(o_empty));
    check_val("o_rd_valid", 64'(1'b0), 64'(o_rd_valid));
    $display("test %0d: kind %0d tag %0d %s", idx, r.kind, r.tag,
             (errors == err0) ? "ok" : "mismatch");
  endtask

  initial begin
    hqm_sif_core = 1'b0;
    i_rst_n      = 1'b0;
    i_valid      = 1'b0;
    i_hdr        = '0;
    i_hdr_par    = 1'b0;
    i_data       = '0;
    i_data_par   = 1'b0;
    i_pop        = 1'b0;
    i_alarm_clr  = 1'b0;
    lfsr         = 32'h2bb986c8;
    outst        = '0;

    // good request and completion pairs.
    tests.push_back(row(K_REQ, 1, 0, 0, 0, IDLE, 0, A_NONE));
    tests.push_back(row(K_CPL, 1, 0, 0, 0, IDLE, 1, A_NONE));
    tests.push_back(row(K_REQ, 2, 0, 0, 0, IDLE, 0, A_NONE));
    tests.push_back(row(K_REQ, 3, 0, 0, 0, IDLE, 0, A_NONE));
    tests.push_back(row(K_CPL, 2, 0, 0, 0, IDLE, 0, A_NONE));
    tests.push_back(row(K_CPL, 3, 0, 0, 0, IDLE, 2, A_NONE));
    // parity and malformed drops.
    tests.push_back(row(K_REQ, 4, 0, 0, 1, IDLE, 0, A_NONE));
    tests.push_back(row(K_CPL, 4, 0, 1, 0, IDLE, 0, A_HP));
    tests.push_back(row(K_CPL, 4, 0, 0, 1, IDLE, 0, A_DP));
    tests.push_back(row(K_CPL, 4, 0, 0, 0, IDLE, 1, A_NONE));
    tests.push_back(row(K_REQ, 5, 0, 1, 0, IDLE, 0, A_HP));
    tests.push_back(row(K_CPL, 5, 0, 0, 0, IDLE, 0, A_UX));
    tests.push_back(row(K_RSV2, 6, 0, 0, 0, IDLE, 0, A_MF));
    tests.push_back(row(K_RSV3, 6, 0, 0, 0, IDLE, 0, A_MF));
    // unexpected and bad-status completions.
    tests.push_back(row(K_CPL, 7, 0, 0, 0, IDLE, 0, A_UX));
    tests.push_back(row(K_REQ, 0, 0, 0, 0, IDLE, 0, A_NONE));
    tests.push_back(row(K_CPL, 0, 2, 0, 0, IDLE, 0, A_NONE));
    tests.push_back(row(K_CPL, 0, 0, 0, 0, IDLE, 0, A_UX));
    // request left to expire.
    tests.push_back(row(K_REQ, 6, 0, 0, 0, 70, 0, A_TO));
    tests.push_back(row(K_CPL, 6, 0, 0, 0, IDLE, 0, A_UX));
    // nine completions into eight entries.
    for (int i = 0; i < 9; i++) begin
      tests.push_back(row(K_REQ, 3'(i % 8), 0, 0, 0, IDLE, 0, A_NONE));
      tests.push_back(row(K_CPL, 3'(i % 8), 0, 0, 0, IDLE, 0, (i == 8) ? A_OV : A_NONE));
    end
    tests.push_back(row(K_NONE, 0, 0, 0, 0, 0, 9, A_UF));
    tests.push_back(row(K_NONE, 0, 0, 0, 0, 0, 1, A_UF));

    limit = 10 + sif_alarm_pkg::SIF_TIMEOUT + 50;
    foreach (tests[i]) begin
      limit += 6 + tests[i].idle + 3 * tests[i].pops;
    end

    repeat (10) @(posedge hqm_sif_core);
    i_rst_n <= 1'b1;
    @(negedge hqm_sif_core);
    check_val("o_rd_valid", 64'(1'b0), 64'(o_rd_valid));
    check_val("o_empty", 64'(1'b1), 64'(o_empty));
    check_val("o_alarm", 64'(A_NONE), 64'(o_alarm));

    foreach (tests[i]) begin
      run_test(i, tests[i]);
    end

    $display("tests %0d, checks %0d, errors %0d", tests.size(), checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* sif_cpl_core.f */
hdl/sif_cpl_pkg.sv
hdl/sif_alarm_pkg.sv
hdl/sif_cpl_decode.sv
hdl/sif_cpl_scrbd.sv
hdl/sif_cpl_result.sv
hdl/sif_cpl_core.sv
verification/sif_cpl_assert.sv
verification/sif_cpl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module sif_cpl_tb \
  -f sif_cpl_core.f -o sif_cpl_sim
./obj_dir/sif_cpl_sim | tee sim.log

if grep -q "^Verification passed$" sim.log; then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi
